//--- hw/iobus_pkg.sv
package iobus_pkg;

	// message opcode, upper nibble of byte 0
	// requests keep their codes, ok and pe use free codes so that no two members share a value
	typedef enum logic [3:0] {
		CMD_PA = 4'h0,	// interrupt pass, request
		CMD_EN = 4'h1,	// engaged, response
		CMD_W  = 4'h2,	// write, request
		CMD_R  = 4'h3,	// read, request
		CMD_OK = 4'h4,	// done, response
		CMD_PE = 4'h5	// parity error, response
	} cmd_e;

	// bus_fsm states
	typedef enum logic [2:0] {
		IDLE,		// nothing in flight
		L_REQ,		// local request sent, waiting for peer response
		L_DONE,		// answer given, waiting for master to drop
		R_ARB,		// remote request, zg up, waiting for zw
		R_DRIVE,	// remote fields on the bus
		TX_WAIT		// reply going out
	} fsm_e;

	localparam logic MSG_REQ  = 1'b1;	// request flag values
	localparam logic MSG_RESP = 1'b0;

	localparam int OP_MSB  = 7;	// byte 0 opcode field
	localparam int OP_LSB  = 4;
	localparam int REQ_BIT = 3;	// byte 0 request flag
	localparam int PN_BIT  = 7;	// a1 pn position

	localparam int NB_W   = 4;	// nb width
	localparam int WORD_W = 16;	// address and data width

	localparam int BYTE_GAP = 4;	// clocks between tx bytes
	localparam int MAX_ARGS = 5;	// longest argument list

	localparam int GAP_W = $clog2(BYTE_GAP + 1);
	localparam int CNT_W = $clog2(MAX_ARGS + 1);

	localparam logic [CNT_W-1:0] ARG_BAD = '1;	// marks an opcode/flag pair with no meaning

	// argument byte count for a byte 0, ARG_BAD if the pair is not a message
	function automatic logic [CNT_W-1:0] arg_len(input logic [3:0] op, input logic req);
		logic [CNT_W-1:0] n;
		n = ARG_BAD;
		if (req == MSG_REQ) begin
			case (op)
				CMD_W:   n = CNT_W'(5);	// a1 a2 a3
				CMD_R:   n = CNT_W'(3);	// a1 a2
				CMD_PA:  n = CNT_W'(1);	// a1
				default: n = ARG_BAD;
			endcase
		end else begin
			case (op)
				CMD_OK:         n = CNT_W'(2);	// a3
				CMD_PE, CMD_EN: n = CNT_W'(0);
				default:        n = ARG_BAD;
			endcase
		end
		return n;
	endfunction

endpackage

//--- hw/byte_gap_timer.sv
`timescale 1ns/1ps

module byte_gap_timer (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic gap_start,	// (re)load the gap
	output logic gap_tick	// gap elapsed
);

	logic [iobus_pkg::GAP_W-1:0] cnt;	// clocks left in the gap, 0 when idle

	// gap_start in cycle t gives cnt = BYTE_GAP in t+1,
	// so the count reaches 1 exactly BYTE_GAP cycles after the start
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (gap_start) begin
			cnt <= iobus_pkg::GAP_W'(iobus_pkg::BYTE_GAP);	// restart wins over expiry
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;	// run down, park at 0
		end
	end

	assign gap_tick = (cnt == iobus_pkg::GAP_W'(1));	// last gap cycle

endmodule

//--- hw/msg_rx.sv
`timescale 1ns/1ps

module msg_rx (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            rx_valid,	// byte strobe from peer
	input  logic [7:0]                      rx_byte,
	output logic                            cmd_ready,	// message complete, one cycle
	output iobus_pkg::cmd_e                 rx_op,
	output logic                            rx_req,
	output logic                            rx_pn,
	output logic [iobus_pkg::NB_W-1:0]      rx_nb,
	output logic [iobus_pkg::WORD_W-1:0]    rx_ad,
	output logic [iobus_pkg::WORD_W-1:0]    rx_dt
);

	logic                         in_msg;	// collecting arguments
	logic [iobus_pkg::CNT_W-1:0]  cnt;	// argument bytes still to come
	logic [iobus_pkg::CNT_W-1:0]  pos;	// slot of next arg byte, 0 = a1 .. 4 = a3 low
	logic [3:0]                   op_in;	// opcode field of current byte
	logic                         req_in;	// request flag of current byte
	logic [iobus_pkg::CNT_W-1:0]  len;	// arg count if current byte is byte 0
	logic                         hdr_take;	// accepted byte 0
	logic                         arg_take;	// accepted argument byte
	logic                         last_arg;	// final argument byte

	assign op_in    = rx_byte[iobus_pkg::OP_MSB:iobus_pkg::OP_LSB];
	assign req_in   = rx_byte[iobus_pkg::REQ_BIT];
	assign len      = iobus_pkg::arg_len(op_in, req_in);
	assign hdr_take = rx_valid & ~in_msg & (len != iobus_pkg::ARG_BAD);	// junk headers fall through
	assign arg_take = rx_valid & in_msg;
	assign last_arg = arg_take & (cnt == iobus_pkg::CNT_W'(1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			in_msg    <= 1'b0;
			cnt       <= '0;
			pos       <= '0;
			cmd_ready <= 1'b0;
		end else begin
			cmd_ready <= (hdr_take & (len == '0)) | last_arg;	// cycle after last byte
			if (hdr_take) begin
				in_msg <= (len != '0);
				cnt    <= len;
				// requests start at a1, responses carry the tail of the a1..a3 list
				if (req_in == iobus_pkg::MSG_REQ)
					pos <= '0;
				else
					pos <= iobus_pkg::CNT_W'(iobus_pkg::MAX_ARGS) - len;
			end else if (arg_take) begin
				cnt <= cnt - 1'b1;
				pos <= pos + 1'b1;
				if (last_arg)
					in_msg <= 1'b0;	// next byte is a new byte 0
			end
		end
	end

	// decoded fields, held until the next accepted byte 0
	always_ff @(posedge clk_sys) begin
		if (hdr_take) begin
			rx_op  <= iobus_pkg::cmd_e'(op_in);
			rx_req <= req_in;
			rx_pn  <= 1'b0;	// fields absent from the message read as zero
			rx_nb  <= '0;
			rx_ad  <= '0;
			rx_dt  <= '0;
		end else if (arg_take) begin
			case (pos)
				0: begin
					rx_pn <= rx_byte[iobus_pkg::PN_BIT];	// a1
					rx_nb <= rx_byte[iobus_pkg::NB_W-1:0];
				end
				1: rx_ad[iobus_pkg::WORD_W-1:8] <= rx_byte;	// a2 high
				2: rx_ad[7:0] <= rx_byte;	// a2 low
				3: rx_dt[iobus_pkg::WORD_W-1:8] <= rx_byte;	// a3 high
				4: rx_dt[7:0] <= rx_byte;	// a3 low
				default: rx_dt <= rx_dt;
			endcase
		end
	end

endmodule

//--- hw/msg_tx.sv
`timescale 1ns/1ps

module msg_tx (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          tx_send,	// capture and start, one cycle
	input  iobus_pkg::cmd_e               tx_op,
	input  logic                          tx_req,
	input  logic                          tx_local,	// args from local master
	input  logic                          bus_pn,
	input  logic [iobus_pkg::NB_W-1:0]    bus_nb,
	input  logic [iobus_pkg::WORD_W-1:0]  bus_ad,
	input  logic [iobus_pkg::WORD_W-1:0]  bus_dt,
	input  logic [iobus_pkg::WORD_W-1:0]  rdt,	// slave read data for ok replies
	output logic                          tx_busy,
	output logic                          tx_valid,	// byte strobe to peer
	output logic [7:0]                    tx_byte
);

	localparam int ARGS_W = 8 * iobus_pkg::MAX_ARGS;	// widest argument list in bits

	logic [iobus_pkg::CNT_W-1:0]  len;	// arg count of the message being started
	logic [iobus_pkg::CNT_W-1:0]  left;	// arg bytes still to go out
	logic [7:0]                   byte0;
	logic [7:0]                   a1;
	logic [ARGS_W-1:0]            args_full;	// a1 a2 a3 in send order
	logic [ARGS_W-1:0]            args_q;	// next byte sits at the top
	logic                         next_byte;	// gap over and bytes remain
	logic                         gap_start;
	logic                         gap_tick;

	assign len = iobus_pkg::arg_len(tx_op, tx_req);

	always_comb begin
		byte0 = '0;
		byte0[iobus_pkg::OP_MSB:iobus_pkg::OP_LSB] = tx_op;
		byte0[iobus_pkg::REQ_BIT] = tx_req;
		a1 = '0;
		a1[iobus_pkg::PN_BIT] = bus_pn;
		a1[iobus_pkg::NB_W-1:0] = bus_nb;
	end

	assign args_full = {a1, bus_ad, tx_local ? bus_dt : rdt};

	assign next_byte = tx_busy & gap_tick & (left != '0);
	// timer starts in the cycle a byte is loaded, so strobes land BYTE_GAP apart
	assign gap_start = (tx_send & (len != '0)) | (next_byte & (left > iobus_pkg::CNT_W'(1)));

	byte_gap_timer u_gap (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.gap_start (gap_start),
		.gap_tick  (gap_tick)
	);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			tx_busy  <= 1'b0;
			tx_valid <= 1'b0;
			left     <= '0;
		end else begin
			tx_valid <= tx_send | next_byte;
			if (tx_valid && left == '0)
				tx_busy <= 1'b0;	// last byte out this cycle
			if (tx_send) begin
				tx_busy <= 1'b1;
				left    <= len;
			end else if (next_byte) begin
				left <= left - 1'b1;
			end
		end
	end

	// byte shifter
	always_ff @(posedge clk_sys) begin
		if (tx_send) begin
			tx_byte <= byte0;
			if (tx_req == iobus_pkg::MSG_REQ)
				args_q <= args_full;	// requests send from a1 on
			else
				args_q <= args_full << (8 * (iobus_pkg::MAX_ARGS - int'(len)));	// tail only
		end else if (next_byte) begin
			tx_byte <= args_q[ARGS_W-1 -: 8];
			args_q  <= args_q << 8;
		end
	end

endmodule

//--- hw/bus_fsm.sv
`timescale 1ns/1ps

module bus_fsm (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          bus_r,	// local master read
	input  logic                          bus_w,	// local master write
	input  logic                          cmd_ready,	// peer message decoded
	input  iobus_pkg::cmd_e               rx_op,
	input  logic                          rx_req,
	input  logic                          rx_pn,
	input  logic [iobus_pkg::NB_W-1:0]    rx_nb,
	input  logic [iobus_pkg::WORD_W-1:0]  rx_ad,
	input  logic [iobus_pkg::WORD_W-1:0]  rx_dt,
	input  logic                          tx_busy,
	input  logic                          zw,	// bus grant
	input  logic                          rok,	// slave done
	input  logic                          rpe,	// slave parity error
	output logic                          zg,	// bus request
	output logic                          dr,
	output logic                          dw,
	output logic                          dpa,
	output logic                          dpn,
	output logic [iobus_pkg::NB_W-1:0]    dnb,
	output logic [iobus_pkg::WORD_W-1:0]  dad,
	output logic [iobus_pkg::WORD_W-1:0]  ddt,
	output logic                          bus_ok,
	output logic                          bus_pe,
	output logic                          bus_en,
	output logic [iobus_pkg::WORD_W-1:0]  bus_rdata,
	output logic                          tx_send,
	output iobus_pkg::cmd_e               tx_op,
	output logic                          tx_req,
	output logic                          tx_local
);

	iobus_pkg::fsm_e state;
	logic            d_ena;	// remote fields onto the bus
	logic            local_req;	// master holds r or w
	logic            remote_req;	// peer request decoded
	logic            resp_in;	// peer response decoded
	logic            slave_ans;	// rok or rpe
	logic            pa_now;	// interrupt pass taken this cycle
	logic            drive;	// field drivers open

	assign local_req  = bus_r | bus_w;
	assign remote_req = cmd_ready & (rx_req == iobus_pkg::MSG_REQ);
	assign resp_in    = cmd_ready & (rx_req == iobus_pkg::MSG_RESP);
	assign slave_ans  = rok | rpe;
	// pa goes straight through in the decode cycle, local master has priority
	assign pa_now = (state == iobus_pkg::IDLE) & ~local_req & remote_req &
		(rx_op == iobus_pkg::CMD_PA);

	// send strobe is combinational so an ok reply picks up rdt while the slave holds it
	assign tx_send  = ((state == iobus_pkg::IDLE) & local_req) |
		((state == iobus_pkg::R_DRIVE) & slave_ans);
	assign tx_local = (state == iobus_pkg::IDLE);	// only local requests start from idle
	assign tx_req   = tx_local ? iobus_pkg::MSG_REQ : iobus_pkg::MSG_RESP;

	always_comb begin
		if (tx_local)
			tx_op = bus_w ? iobus_pkg::CMD_W : iobus_pkg::CMD_R;
		else
			tx_op = rok ? iobus_pkg::CMD_OK : iobus_pkg::CMD_PE;
	end

	// bus drivers
	assign drive = d_ena | pa_now;
	assign dr    = d_ena & (rx_op == iobus_pkg::CMD_R);
	assign dw    = d_ena & (rx_op == iobus_pkg::CMD_W);
	assign dpa   = pa_now;
	assign dpn   = drive & rx_pn;
	assign dnb   = drive ? rx_nb : '0;
	assign dad   = drive ? rx_ad : '0;
	assign ddt   = drive ? rx_dt : '0;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state  <= iobus_pkg::IDLE;
			zg     <= 1'b0;
			d_ena  <= 1'b0;
			bus_ok <= 1'b0;
			bus_pe <= 1'b0;
			bus_en <= 1'b0;
		end else begin
			bus_ok <= 1'b0;	// answer strobes last one cycle
			bus_pe <= 1'b0;
			bus_en <= 1'b0;
			case (state)
				iobus_pkg::IDLE: begin
					if (local_req) begin
						state <= iobus_pkg::L_REQ;	// request message leaves now
					end else if (remote_req && rx_op != iobus_pkg::CMD_PA) begin
						zg    <= 1'b1;	// r or w needs the bus
						state <= iobus_pkg::R_ARB;
					end
				end
				iobus_pkg::L_REQ: begin
					// peer requests arriving here are dropped
					if (resp_in) begin
						bus_ok <= (rx_op == iobus_pkg::CMD_OK);
						bus_pe <= (rx_op == iobus_pkg::CMD_PE);
						bus_en <= (rx_op == iobus_pkg::CMD_EN);
						state  <= iobus_pkg::L_DONE;
					end
				end
				iobus_pkg::L_DONE: begin
					if (!local_req)
						state <= iobus_pkg::IDLE;	// master let go
				end
				iobus_pkg::R_ARB: begin
					if (zw) begin
						d_ena <= 1'b1;
						state <= iobus_pkg::R_DRIVE;
					end
				end
				iobus_pkg::R_DRIVE: begin
					if (slave_ans) begin
						d_ena <= 1'b0;	// reply starts this cycle
						state <= iobus_pkg::TX_WAIT;
					end
				end
				iobus_pkg::TX_WAIT: begin
					if (!tx_busy) begin
						zg    <= 1'b0;	// reply fully out
						state <= iobus_pkg::IDLE;
					end
				end
				default: state <= iobus_pkg::IDLE;
			endcase
		end
	end

	// read data from the peer's ok
	always_ff @(posedge clk_sys) begin
		if (state == iobus_pkg::L_REQ && resp_in && rx_op == iobus_pkg::CMD_OK)
			bus_rdata <= rx_dt;
	end

endmodule

//--- hw/iobus.sv
`timescale 1ns/1ps

module iobus (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          rx_valid,	// peer byte in
	input  logic [7:0]                    rx_byte,
	output logic                          tx_valid,	// peer byte out
	output logic [7:0]                    tx_byte,
	input  logic                          bus_r,	// local master
	input  logic                          bus_w,
	input  logic                          bus_pn,
	input  logic [iobus_pkg::NB_W-1:0]    bus_nb,
	input  logic [iobus_pkg::WORD_W-1:0]  bus_ad,
	input  logic [iobus_pkg::WORD_W-1:0]  bus_dt,
	output logic                          bus_ok,
	output logic                          bus_pe,
	output logic                          bus_en,
	output logic [iobus_pkg::WORD_W-1:0]  bus_rdata,
	output logic                          zg,	// local bus, remote side
	input  logic                          zw,
	output logic                          dr,
	output logic                          dw,
	output logic                          dpa,
	output logic                          dpn,
	output logic [iobus_pkg::NB_W-1:0]    dnb,
	output logic [iobus_pkg::WORD_W-1:0]  dad,
	output logic [iobus_pkg::WORD_W-1:0]  ddt,
	input  logic                          rok,
	input  logic                          rpe,
	input  logic [iobus_pkg::WORD_W-1:0]  rdt
);

	logic                          cmd_ready;
	iobus_pkg::cmd_e               rx_op;
	logic                          rx_req;
	logic                          rx_pn;
	logic [iobus_pkg::NB_W-1:0]    rx_nb;
	logic [iobus_pkg::WORD_W-1:0]  rx_ad;
	logic [iobus_pkg::WORD_W-1:0]  rx_dt;
	logic                          tx_send;
	iobus_pkg::cmd_e               tx_op;
	logic                          tx_req;
	logic                          tx_local;
	logic                          tx_busy;

	msg_rx u_rx (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.cmd_ready (cmd_ready),
		.rx_op     (rx_op),
		.rx_req    (rx_req),
		.rx_pn     (rx_pn),
		.rx_nb     (rx_nb),
		.rx_ad     (rx_ad),
		.rx_dt     (rx_dt)
	);

	msg_tx u_tx (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.tx_send  (tx_send),
		.tx_op    (tx_op),
		.tx_req   (tx_req),
		.tx_local (tx_local),
		.bus_pn   (bus_pn),
		.bus_nb   (bus_nb),
		.bus_ad   (bus_ad),
		.bus_dt   (bus_dt),
		.rdt      (rdt),
		.tx_busy  (tx_busy),
		.tx_valid (tx_valid),
		.tx_byte  (tx_byte)
	);

	bus_fsm u_fsm (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.bus_r     (bus_r),
		.bus_w     (bus_w),
		.cmd_ready (cmd_ready),
		.rx_op     (rx_op),
		.rx_req    (rx_req),
		.rx_pn     (rx_pn),
		.rx_nb     (rx_nb),
		.rx_ad     (rx_ad),
		.rx_dt     (rx_dt),
		.tx_busy   (tx_busy),
		.zw        (zw),
		.rok       (rok),
		.rpe       (rpe),
		.zg        (zg),
		.dr        (dr),
		.dw        (dw),
		.dpa       (dpa),
		.dpn       (dpn),
		.dnb       (dnb),
		.dad       (dad),
		.ddt       (ddt),
		.bus_ok    (bus_ok),
		.bus_pe    (bus_pe),
		.bus_en    (bus_en),
		.bus_rdata (bus_rdata),
		.tx_send   (tx_send),
		.tx_op     (tx_op),
		.tx_req    (tx_req),
		.tx_local  (tx_local)
	);

endmodule

//--- verif/iobus_model.svh
// xorshift32 step on the shared seed
function automatic logic [31:0] rand32();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

function automatic int rand_upto(input int hi);	// 0 .. hi
	logic [31:0] r;
	r = rand32();
	return int'(r % 32'(hi + 1));
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		errors++;
	end
endtask

function automatic logic [7:0] hdr(input logic [3:0] op, input logic req);
	return {op, req, 3'b000};	// opcode, request flag, zero pad
endfunction

// argument bytes per message type, -1 for anything undefined
function automatic int expect_args(input logic [7:0] b0);
	if (b0[3]) begin
		case (b0[7:4])
			iobus_pkg::CMD_W:  return 5;
			iobus_pkg::CMD_R:  return 3;
			iobus_pkg::CMD_PA: return 1;
			default:           return -1;
		endcase
	end
	case (b0[7:4])
		iobus_pkg::CMD_OK: return 2;
		iobus_pkg::CMD_PE: return 0;
		iobus_pkg::CMD_EN: return 0;
		default:           return -1;
	endcase
endfunction

// peer side, strobes pkt[0..n-1] with 0..3 idle cycles before each byte
task automatic send_msg(input int n, input bit raise);
	int i;
	int g;
	for (i = 0; i < n; i++) begin
		g = rand_upto(3);
		repeat (g) begin
			@(posedge clk_sys);
			rx_valid <= 1'b0;
		end
		@(posedge clk_sys);
		rx_valid <= 1'b1;
		rx_byte  <= pkt[i];
		if (raise && i == n - 1)
			drive_master();	// local request in the same cycle as the last byte
	end
	@(posedge clk_sys);
	rx_valid <= 1'b0;
endtask

// gathers one tx message from the monitor queue, length taken from its header
task automatic collect_msg();
	int n;
	int i;
	int want;
	int e0;
	for (n = 0; n < 200 && tx_q.size() == 0; n++)
		@(posedge clk_sys);
	if (tx_q.size() == 0) begin
		timed_out("the first tx byte of a message");
		return;
	end
	want = 1 + expect_args(tx_q[0]);
	if (want < 1) begin
		$display("tx header 0x%h is not a defined message", tx_q[0]);
		errors++;
		want = 1;
	end
	for (n = 0; n < 100 && tx_q.size() < want; n++)
		@(posedge clk_sys);
	if (tx_q.size() < want) begin
		timed_out("the remaining tx bytes of a message");
		return;
	end
	repeat (2 * iobus_pkg::BYTE_GAP) @(posedge clk_sys);	// window for stray extra bytes
	e0 = errors;
	check("tx_msg_len", tx_q.size(), want);
	for (i = 0; i < want; i++) begin
		got_msg[i] = tx_q[i];
		if (i > 0)
			check("tx_valid_gap", tx_t[i] - tx_t[i-1], iobus_pkg::BYTE_GAP);
	end
	pace_errs += errors - e0;
	got_len = want;
	last_t  = tx_t[want-1];
	tx_q.delete();
	tx_t.delete();
endtask

// peer request served through the local slave, optional junk byte in front
task automatic remote_txn(input bit garbage);
	logic [31:0]                 r;
	logic                        w;
	logic                        pe;
	logic                        pn;
	logic [iobus_pkg::NB_W-1:0]  nb;
	logic [iobus_pkg::WORD_W-1:0] ad;
	logic [iobus_pkg::WORD_W-1:0] dt;
	logic [iobus_pkg::WORD_W-1:0] data;
	logic [3:0]                  bad;
	int                          k;
	int                          n;
	r    = rand32();
	w    = r[0];
	pn   = r[1];
	nb   = r[7:4];
	ad   = r[23:8];
	pe   = (r[27:26] == 2'b00);	// roughly one parity error in four
	r    = rand32();
	dt   = r[15:0];
	data = r[31:16];
	k    = 0;
	if (garbage) begin
		bad    = 4'(6 + rand_upto(9));	// codes 6..15 are unused
		pkt[k] = {bad, dt[3:0]};
		k++;
	end
	pkt[k]   = hdr(w ? iobus_pkg::CMD_W : iobus_pkg::CMD_R, 1'b1);
	pkt[k+1] = {pn, 3'b000, nb};	// a1
	pkt[k+2] = ad[15:8];
	pkt[k+3] = ad[7:0];
	k += 4;
	if (w) begin
		pkt[k]   = dt[15:8];	// a3 only on writes
		pkt[k+1] = dt[7:0];
		k += 2;
	end
	clear_mon();
	send_msg(k, 1'b0);
	for (n = 0; n < 60 && n_zg_rise == 0; n++)
		@(posedge clk_sys);
	if (n_zg_rise == 0) begin
		timed_out("zg to rise");
		return;
	end
	repeat (rand_upto(10)) @(posedge clk_sys);	// grant delay
	@(posedge clk_sys);
	zw <= 1'b1;
	for (n = 0; n < 30 && !seen_drv; n++)
		@(posedge clk_sys);
	if (!seen_drv) begin
		timed_out("dr or dw after the grant");
		return;
	end
	check("dr", drv_r, !w);
	check("dw", drv_w, w);
	check("dpn", drv_pn, pn);
	check("dnb", drv_nb, nb);
	check("dad", drv_ad, ad);
	if (w)
		check("ddt", drv_dt, dt);
	repeat (rand_upto(10)) @(posedge clk_sys);	// slave answer delay
	@(posedge clk_sys);
	rok <= !pe;
	rpe <= pe;
	rdt <= data;
	@(posedge clk_sys);
	rok <= 1'b0;
	rpe <= 1'b0;
	collect_msg();
	if (aborted)
		return;
	check("tx_byte0", got_msg[0], hdr(pe ? iobus_pkg::CMD_PE : iobus_pkg::CMD_OK, 1'b0));
	if (!pe) begin
		check("tx_rdt_hi", got_msg[1], data[15:8]);
		check("tx_rdt_lo", got_msg[2], data[7:0]);
	end
	for (n = 0; n < 60 && n_zg_fall == 0; n++)
		@(posedge clk_sys);
	if (n_zg_fall == 0) begin
		timed_out("zg to fall after the reply");
		return;
	end
	check("zg_fall_after_last_byte", zg_fall_t > last_t, 1);
	check("zg_requests", n_zg_rise, 1);	// junk header must not start a second one
	@(posedge clk_sys);
	zw <= 1'b0;
	repeat (2) @(posedge clk_sys);
endtask

//--- verif/tb_iobus.sv
`timescale 1ns/1ps

module tb_iobus;

	logic                          clk_sys;
	logic                          rst_n;
	logic                          rx_valid;
	logic [7:0]                    rx_byte;
	logic                          tx_valid;
	logic [7:0]                    tx_byte;
	logic                          bus_r;
	logic                          bus_w;
	logic                          bus_pn;
	logic [iobus_pkg::NB_W-1:0]    bus_nb;
	logic [iobus_pkg::WORD_W-1:0]  bus_ad;
	logic [iobus_pkg::WORD_W-1:0]  bus_dt;
	logic                          bus_ok;
	logic                          bus_pe;
	logic                          bus_en;
	logic [iobus_pkg::WORD_W-1:0]  bus_rdata;
	logic                          zg;
	logic                          zw;
	logic                          dr;
	logic                          dw;
	logic                          dpa;
	logic                          dpn;
	logic [iobus_pkg::NB_W-1:0]    dnb;
	logic [iobus_pkg::WORD_W-1:0]  dad;
	logic [iobus_pkg::WORD_W-1:0]  ddt;
	logic                          rok;
	logic                          rpe;
	logic [iobus_pkg::WORD_W-1:0]  rdt;

	int          errors;	// mismatches and timeouts
	bit          aborted;	// a wait ran out, remaining tests skipped
	int          n_tests;
	int          n_bad;
	int          pace_errs;
	logic [31:0] rng_state;

	int          cyc;	// monitor cycle count
	logic [7:0]  tx_q[$];	// tx bytes seen
	int          tx_t[$];	// their cycles
	int          n_ok;
	int          n_pe;
	int          n_en;
	int          n_pa;
	logic [iobus_pkg::NB_W-1:0]   pa_nb;
	int          n_zg_rise;
	int          n_zg_fall;
	int          zg_fall_t;
	logic        zg_d;
	bit          seen_drv;	// first cycle of dr or dw captured
	logic        drv_r;
	logic        drv_w;
	logic        drv_pn;
	logic [iobus_pkg::NB_W-1:0]   drv_nb;
	logic [iobus_pkg::WORD_W-1:0] drv_ad;
	logic [iobus_pkg::WORD_W-1:0] drv_dt;

	logic [7:0]  pkt[0:6];	// peer bytes to send
	logic [7:0]  got_msg[0:5];	// last collected tx message
	int          got_len;
	int          last_t;

	logic                         m_w;	// local master request
	logic                         m_pn;
	logic [iobus_pkg::NB_W-1:0]   m_nb;
	logic [iobus_pkg::WORD_W-1:0] m_ad;
	logic [iobus_pkg::WORD_W-1:0] m_dt;

	iobus dut (.*);

	always #20 clk_sys = ~clk_sys;

	// outputs sampled mid-cycle, away from the driving edge
	always @(negedge clk_sys) begin
		cyc++;
		if (tx_valid) begin
			tx_q.push_back(tx_byte);
			tx_t.push_back(cyc);
		end
		if (bus_ok)
			n_ok++;
		if (bus_pe)
			n_pe++;
		if (bus_en)
			n_en++;
		if (dpa) begin
			n_pa++;
			pa_nb = dnb;
		end
		if ((dr || dw) && !seen_drv) begin
			seen_drv = 1'b1;
			drv_r    = dr;
			drv_w    = dw;
			drv_pn   = dpn;
			drv_nb   = dnb;
			drv_ad   = dad;
			drv_dt   = ddt;
		end
		if (zg && !zg_d)
			n_zg_rise++;
		if (!zg && zg_d) begin
			n_zg_fall++;
			zg_fall_t = cyc;
		end
		zg_d = zg;
	end

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
		aborted = 1'b1;
	endtask

	task automatic clear_mon();
		tx_q.delete();
		tx_t.delete();
		n_ok      = 0;
		n_pe      = 0;
		n_en      = 0;
		n_pa      = 0;
		n_zg_rise = 0;
		n_zg_fall = 0;
		seen_drv  = 1'b0;
	endtask

	`include "iobus_model.svh"

	task automatic pick_master();
		logic [31:0] r;
		r    = rand32();
		m_w  = r[0];
		m_pn = r[1];
		m_nb = r[7:4];
		m_ad = r[23:8];
		r    = rand32();
		m_dt = r[15:0];
	endtask

	task automatic drive_master();	// called right after a rising edge
		bus_w  <= m_w;
		bus_r  <= !m_w;
		bus_pn <= m_pn;
		bus_nb <= m_nb;
		bus_ad <= m_ad;
		bus_dt <= m_dt;
	endtask

	// request message out, peer answer back, one answer strobe expected
	task automatic finish_local();
		logic [31:0] r;
		int          kind;	// 0 ok, 1 pe, 2 en
		int          n;
		collect_msg();
		if (aborted)
			return;
		check("tx_byte0", got_msg[0], hdr(m_w ? iobus_pkg::CMD_W : iobus_pkg::CMD_R, 1'b1));
		check("tx_req_len", got_len, m_w ? 6 : 4);	// header plus a1 a2, a3 on writes
		check("tx_a1", got_msg[1], {m_pn, 3'b000, m_nb});
		check("tx_ad_hi", got_msg[2], m_ad[15:8]);
		check("tx_ad_lo", got_msg[3], m_ad[7:0]);
		if (m_w) begin
			check("tx_dt_hi", got_msg[4], m_dt[15:8]);
			check("tx_dt_lo", got_msg[5], m_dt[7:0]);
		end
		r    = rand32();
		kind = rand_upto(2);
		pkt[0] = hdr(kind == 0 ? iobus_pkg::CMD_OK :
			kind == 1 ? iobus_pkg::CMD_PE : iobus_pkg::CMD_EN, 1'b0);
		pkt[1] = r[15:8];	// a3, read data
		pkt[2] = r[7:0];
		send_msg(kind == 0 ? 3 : 1, 1'b0);
		for (n = 0; n < 60 && n_ok + n_pe + n_en == 0; n++)
			@(posedge clk_sys);
		if (n_ok + n_pe + n_en == 0) begin
			timed_out("the local answer strobe");
			return;
		end
		repeat (4) @(posedge clk_sys);	// room for a duplicate strobe
		check("bus_ok", n_ok, kind == 0);
		check("bus_pe", n_pe, kind == 1);
		check("bus_en", n_en, kind == 2);
		if (kind == 0)
			check("bus_rdata", bus_rdata, r[15:0]);
		@(posedge clk_sys);
		bus_r <= 1'b0;
		bus_w <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic local_txn();
		pick_master();
		clear_mon();
		@(posedge clk_sys);
		drive_master();
		finish_local();
	endtask

	task automatic pa_txn();
		logic [31:0] r;
		r = rand32();
		pkt[0] = hdr(iobus_pkg::CMD_PA, 1'b1);
		pkt[1] = {r[0], 3'b000, r[7:4]};
		clear_mon();
		send_msg(2, 1'b0);
		repeat (30) @(posedge clk_sys);	// pa has no reply
		check("dpa_pulses", n_pa, 1);
		check("dnb", pa_nb, r[7:4]);
		check("tx_bytes", tx_q.size(), 0);
		check("zg_requests", n_zg_rise, 0);
	endtask

	// remote write whose last byte meets a local request
	task automatic priority_txn();
		logic [31:0] r;
		r = rand32();
		pick_master();
		pkt[0] = hdr(iobus_pkg::CMD_W, 1'b1);
		pkt[1] = {r[0], 3'b000, r[7:4]};
		pkt[2] = r[15:8];
		pkt[3] = r[23:16];
		pkt[4] = r[31:24];
		pkt[5] = r[11:4];
		clear_mon();
		send_msg(6, 1'b1);
		finish_local();
		if (aborted)
			return;
		repeat (10) @(posedge clk_sys);
		check("tx_bytes", tx_q.size(), 0);	// remote request dropped
		check("zg_requests", n_zg_rise, 0);
		check("dr_dw_seen", seen_drv, 0);
	endtask

	task automatic end_test(input string name, input int fails);
		n_tests++;
		if (fails != 0)
			n_bad++;
		$display("test %-16s %0d mismatches", name, fails);
	endtask

	initial begin
		int e0;
		int i;
		clk_sys   = 1'b0;
		rst_n     = 1'b0;
		rx_valid  = 1'b0;
		rx_byte   = '0;
		bus_r     = 1'b0;
		bus_w     = 1'b0;
		bus_pn    = 1'b0;
		bus_nb    = '0;
		bus_ad    = '0;
		bus_dt    = '0;
		zw        = 1'b0;
		rok       = 1'b0;
		rpe       = 1'b0;
		rdt       = '0;
		rng_state = 32'h420f42aa;
		errors    = 0;
		aborted   = 1'b0;
		n_tests   = 0;
		n_bad     = 0;
		pace_errs = 0;
		cyc       = 0;
		zg_d      = 1'b0;
		clear_mon();
		repeat (4) @(posedge clk_sys);
		rst_n <= 1'b1;
		e0 = errors;
		@(negedge clk_sys);
		check("tx_valid", tx_valid, 0);
		check("zg", zg, 0);
		check("dr", dr, 0);
		check("dw", dw, 0);
		check("dpa", dpa, 0);
		check("dpn", dpn, 0);
		check("dnb", dnb, 0);
		check("dad", dad, 0);
		check("ddt", ddt, 0);
		check("bus_ok", bus_ok, 0);
		check("bus_pe", bus_pe, 0);
		check("bus_en", bus_en, 0);
		check("cmd_ready", dut.u_rx.cmd_ready, 0);
		end_test("reset_values", errors - e0);
		repeat (2) @(posedge clk_sys);
		e0 = errors;
		for (i = 0; i < 20 && !aborted; i++)
			local_txn();
		end_test("local_rw", errors - e0);
		e0 = errors;
		for (i = 0; i < 20 && !aborted; i++)
			remote_txn(1'b0);
		end_test("remote_rw", errors - e0);
		e0 = errors;
		for (i = 0; i < 5 && !aborted; i++)
			pa_txn();
		end_test("remote_pa", errors - e0);
		e0 = errors;
		for (i = 0; i < 5 && !aborted; i++) begin
			remote_txn(1'b1);
			if (!aborted)
				priority_txn();
		end
		end_test("garbage_priority", errors - e0);
		end_test("pacing", pace_errs);
		$display("%0d tests run, %0d with mismatches, %0d mismatches in all",
			n_tests, n_bad, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- iobus.f
+incdir+verif
hw/iobus_pkg.sv
hw/byte_gap_timer.sv
hw/msg_rx.sv
hw/msg_tx.sv
hw/bus_fsm.sv
hw/iobus.sv
verif/tb_iobus.sv

//--- run_sim.sh
#!/bin/sh
# build the iobus testbench with verilator, run it, then scan the log

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_iobus -f iobus.f -Mdir obj_dir -o tb_iobus
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_iobus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
exit 0
